/* verilog/jtag_pkg.sv */
package jtag_pkg;

  // ########################################
  // TAP state indices into the one-hot word
  // ########################################
  typedef enum logic [3:0] {
    ST_TEST_LOGIC_RESET = 4'd0,
    ST_RUN_IDLE         = 4'd1,
    ST_SELECT_DR        = 4'd2,
    ST_CAPTURE_DR       = 4'd3,
    ST_SHIFT_DR         = 4'd4,
    ST_EXIT1_DR         = 4'd5,
    ST_PAUSE_DR         = 4'd6,
    ST_EXIT2_DR         = 4'd7,
    ST_UPDATE_DR        = 4'd8,
    ST_SELECT_IR        = 4'd9,
    ST_CAPTURE_IR       = 4'd10,
    ST_SHIFT_IR         = 4'd11,
    ST_EXIT1_IR         = 4'd12,
    ST_PAUSE_IR         = 4'd13,
    ST_EXIT2_IR         = 4'd14,
    ST_UPDATE_IR        = 4'd15
  } tap_state_e;

  localparam int TAP_STATES = 16;
  localparam int IR_WIDTH   = 5;
  localparam int USR_WIDTH  = 3;
  localparam int ID_WIDTH   = 32;

  // ########################################
  // Instruction codes
  // ########################################
  localparam logic [IR_WIDTH-1:0] INSN_EXTEST  = 5'b0_0000;
  localparam logic [IR_WIDTH-1:0] INSN_IDCODE  = 5'b0_0001;
  localparam logic [IR_WIDTH-1:0] INSN_SAMPLE  = 5'b0_0010;
  localparam logic [IR_WIDTH-1:0] INSN_INTEST  = 5'b0_0100;
  localparam logic [IR_WIDTH-1:0] INSN_HIZ     = 5'b0_0101;
  localparam logic [IR_WIDTH-1:0] INSN_CLAMP   = 5'b0_0110;
  localparam logic [IR_WIDTH-1:0] INSN_BYPASS1 = 5'b0_0111;
  localparam logic [IR_WIDTH-1:0] INSN_CUST0   = 5'b1_1000;
  localparam logic [IR_WIDTH-1:0] INSN_CUST1   = 5'b1_1001;
  localparam logic [IR_WIDTH-1:0] INSN_CUST2   = 5'b1_1010;
  localparam logic [IR_WIDTH-1:0] INSN_CUST3   = 5'b1_1011;
  localparam logic [IR_WIDTH-1:0] INSN_BYPASS  = 5'b1_1111;

endpackage

/* verilog/jtag_tap_fsm.sv */
`timescale 1ns/100ps

module jtag_tap_fsm
  import jtag_pkg::*;
(
  input  logic JTAG_CLOCK,
  input  logic reset_N,
  input  logic tms,
  output logic capture_dr,
  output logic shift_dr,
  output logic update_dr,
  output logic capture_ir,
  output logic shift_ir,
  output logic update_ir,
  output logic run_idle,
  output logic test_logic_reset
);

  logic [TAP_STATES-1:0] state_q;
  logic [TAP_STATES-1:0] state_d;

  // ########################################
  // Next state, IEEE 1149.1 graph
  // ########################################
  always_comb
  begin
    state_d = '0;
    unique case (1'b1)
      state_q[ST_TEST_LOGIC_RESET]:
        state_d[tms ? ST_TEST_LOGIC_RESET : ST_RUN_IDLE] = 1'b1;
      state_q[ST_RUN_IDLE]:
        state_d[tms ? ST_SELECT_DR : ST_RUN_IDLE] = 1'b1;
      state_q[ST_SELECT_DR]:
        state_d[tms ? ST_SELECT_IR : ST_CAPTURE_DR] = 1'b1;
      state_q[ST_CAPTURE_DR]:
        state_d[tms ? ST_EXIT1_DR : ST_SHIFT_DR] = 1'b1;
      state_q[ST_SHIFT_DR]:
        state_d[tms ? ST_EXIT1_DR : ST_SHIFT_DR] = 1'b1;
      state_q[ST_EXIT1_DR]:
        state_d[tms ? ST_UPDATE_DR : ST_PAUSE_DR] = 1'b1;
      state_q[ST_PAUSE_DR]:
        state_d[tms ? ST_EXIT2_DR : ST_PAUSE_DR] = 1'b1;
      state_q[ST_EXIT2_DR]:
        state_d[tms ? ST_UPDATE_DR : ST_SHIFT_DR] = 1'b1;
      state_q[ST_UPDATE_DR]:
        state_d[tms ? ST_SELECT_DR : ST_RUN_IDLE] = 1'b1;
      state_q[ST_SELECT_IR]:
        state_d[tms ? ST_TEST_LOGIC_RESET : ST_CAPTURE_IR] = 1'b1;
      state_q[ST_CAPTURE_IR]:
        state_d[tms ? ST_EXIT1_IR : ST_SHIFT_IR] = 1'b1;
      state_q[ST_SHIFT_IR]:
        state_d[tms ? ST_EXIT1_IR : ST_SHIFT_IR] = 1'b1;
      state_q[ST_EXIT1_IR]:
        state_d[tms ? ST_UPDATE_IR : ST_PAUSE_IR] = 1'b1;
      state_q[ST_PAUSE_IR]:
        state_d[tms ? ST_EXIT2_IR : ST_PAUSE_IR] = 1'b1;
      state_q[ST_EXIT2_IR]:
        state_d[tms ? ST_UPDATE_IR : ST_SHIFT_IR] = 1'b1;
      state_q[ST_UPDATE_IR]:
        state_d[tms ? ST_SELECT_DR : ST_RUN_IDLE] = 1'b1;
      default:
        state_d[ST_TEST_LOGIC_RESET] = 1'b1; // Recover from a corrupt word
    endcase
  end

  always_ff @(posedge JTAG_CLOCK or negedge reset_N)
  begin
    if (!reset_N)
    begin
      state_q <= '0;
      state_q[ST_TEST_LOGIC_RESET] <= 1'b1;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Strobes are plain state bits
  assign capture_dr       = state_q[ST_CAPTURE_DR];
  assign shift_dr         = state_q[ST_SHIFT_DR];
  assign update_dr        = state_q[ST_UPDATE_DR];
  assign capture_ir       = state_q[ST_CAPTURE_IR];
  assign shift_ir         = state_q[ST_SHIFT_IR];
  assign update_ir        = state_q[ST_UPDATE_IR];
  assign run_idle         = state_q[ST_RUN_IDLE];
  assign test_logic_reset = state_q[ST_TEST_LOGIC_RESET];

  // ########################################
  // Checks
  // ########################################
  a_state_onehot: assert property (
    @(posedge JTAG_CLOCK) disable iff (!reset_N)
    $onehot(state_q)
  ) else $error("TAP state word not one-hot: %b", state_q);

  // Five cycles of tms high always land in Test-Logic-Reset
  a_tms_reset: assert property (
    @(posedge JTAG_CLOCK) disable iff (!reset_N)
    tms [*5] |=> state_q[ST_TEST_LOGIC_RESET]
  ) else $error("TAP did not reach Test-Logic-Reset after five tms cycles");

endmodule

/* verilog/jtag_ir.sv */
`timescale 1ns/100ps

module jtag_ir
  import jtag_pkg::*;
(
  input  logic                 JTAG_CLOCK,
  input  logic                 reset_N,
  input  logic                 tdi,
  input  logic [USR_WIDTH-1:0] user_status,
  input  logic                 capture_ir,
  input  logic                 shift_ir,
  input  logic                 update_ir,
  input  logic                 test_logic_reset,
  output logic [IR_WIDTH-1:0]  ir,
  output logic                 ir_tdo,
  output logic                 sel_boundary,
  output logic                 sel_bypass,
  output logic                 sel_idcode,
  output logic                 sel_extension
);

  logic [IR_WIDTH-1:0] ir_scan;

  // ########################################
  // Scan and hold registers
  // ########################################
  always_ff @(posedge JTAG_CLOCK or negedge reset_N)
  begin
    if (!reset_N)
    begin
      ir_scan <= '0;
      ir      <= INSN_IDCODE;
    end
    else
    begin
      if (capture_ir)
        ir_scan <= {user_status, 2'b01}; // Status plus fixed 01 marker
      else if (shift_ir)
        ir_scan <= {tdi, ir_scan[IR_WIDTH-1:1]};

      if (test_logic_reset)
        ir <= INSN_IDCODE;
      else if (update_ir)
        ir <= ir_scan;
    end
  end

  assign ir_tdo = ir_scan[0];

  // Chain decode of the held instruction
  always_comb
  begin
    sel_boundary  = 1'b0;
    sel_bypass    = 1'b0;
    sel_idcode    = 1'b0;
    sel_extension = 1'b0;
    case (ir)
      INSN_EXTEST, INSN_SAMPLE,
      INSN_CUST0, INSN_CUST1, INSN_CUST2, INSN_CUST3:
        sel_boundary = 1'b1;
      INSN_INTEST, INSN_HIZ, INSN_CLAMP, INSN_BYPASS1, INSN_BYPASS:
        sel_bypass = 1'b1;
      INSN_IDCODE:
        sel_idcode = 1'b1;
      default:
        sel_extension = 1'b1; // Debug chain
    endcase
  end

  a_one_select: assert property (
    @(posedge JTAG_CLOCK) disable iff (!reset_N)
    $onehot({sel_boundary, sel_bypass, sel_idcode, sel_extension})
  ) else $error("Chain selects not one-hot for ir %b", ir);

endmodule

/* verilog/jtag_id_bypass.sv */
`timescale 1ns/100ps

module jtag_id_bypass
  import jtag_pkg::*;
#(
  parameter logic [ID_WIDTH-2:0] ID_CODE = '0
)
(
  input  logic JTAG_CLOCK,
  input  logic reset_N,
  input  logic tdi,
  input  logic capture_dr,
  input  logic shift_dr,
  input  logic sel_idcode,
  input  logic sel_bypass,
  input  logic sel_boundary,
  input  logic sel_extension,
  output logic dr_tdo,
  output logic scan_in,
  output logic escan_in
);

  logic [ID_WIDTH-1:0] id_scan;
  logic                byp_scan;

  // ########################################
  // Internal data registers
  // ########################################
  always_ff @(posedge JTAG_CLOCK or negedge reset_N)
  begin
    if (!reset_N)
    begin
      id_scan  <= '0;
      byp_scan <= 1'b0;
    end
    else
    begin
      if (capture_dr && sel_idcode)
        id_scan <= {ID_CODE, 1'b1}; // Bit 0 fixed high
      else if (shift_dr && sel_idcode)
        id_scan <= {tdi, id_scan[ID_WIDTH-1:1]};

      if (shift_dr && sel_bypass)
        byp_scan <= tdi; // No capture, keeps last bit
    end
  end

  assign dr_tdo = sel_idcode ? id_scan[0] : byp_scan;

  // External chains see tdi only while shifting
  assign scan_in  = shift_dr & sel_boundary & tdi;
  assign escan_in = shift_dr & sel_extension & tdi;

  a_chain_exclusive: assert property (
    @(posedge JTAG_CLOCK) disable iff (!reset_N)
    !(scan_in && escan_in)
  ) else $error("Boundary and extension chains both driven");

endmodule

/* verilog/jtag_tdo_mux.sv */
`timescale 1ns/100ps

module jtag_tdo_mux
(
  input  logic JTAG_CLOCK,
  input  logic reset_N,
  input  logic tdi,
  input  logic shift_ir,
  input  logic shift_dr,
  input  logic sel_boundary,
  input  logic sel_extension,
  input  logic ir_tdo,
  input  logic dr_tdo,
  input  logic scan_out,
  input  logic escan_out,
  input  logic probe_enable,
  input  logic probe_tdo,
  output logic tdo,
  output logic debug_int
);

  logic shift_bit;
  logic tdo_q;

  // ########################################
  // Serial source for the shift state
  // ########################################
  always_comb
  begin
    if (shift_ir)
      shift_bit = ir_tdo;
    else if (sel_boundary)
      shift_bit = scan_out;
    else if (sel_extension)
      shift_bit = escan_out;
    else
      shift_bit = dr_tdo; // IDCODE or bypass
  end

  // Falling-edge retime, holds outside shift states
  always_ff @(negedge JTAG_CLOCK or negedge reset_N)
  begin
    if (!reset_N)
      tdo_q <= 1'b0;
    else if (shift_ir || shift_dr)
      tdo_q <= shift_bit;
  end

  // Probe takes over the pin
  assign tdo       = probe_enable ? probe_tdo : tdo_q;
  assign debug_int = probe_enable & ~tdi;

endmodule

/* verilog/jtag_tap_top.sv */
`timescale 1ns/100ps

module jtag_tap_top
  import jtag_pkg::*;
#(
  parameter logic [ID_WIDTH-2:0] ID_CODE = 31'h0A5C_3E27
)
(
  input  logic                 JTAG_CLOCK,
  input  logic                 reset_N,
  input  logic                 tms,
  input  logic                 tdi,
  input  logic [USR_WIDTH-1:0] user_status,
  input  logic                 scan_out,
  input  logic                 escan_out,
  input  logic                 probe_enable,
  input  logic                 probe_tdo,
  output logic                 tdo,
  output logic                 scan_in,
  output logic                 escan_in,
  output logic                 capture_dr,
  output logic                 shift_dr,
  output logic                 update_dr,
  output logic                 shift_ir,
  output logic                 run_idle,
  output logic                 test_logic_reset,
  output logic [IR_WIDTH-1:0]  ir,
  output logic                 debug_int
);

  logic capture_ir;
  logic update_ir;
  logic ir_tdo;
  logic dr_tdo;
  logic sel_boundary;
  logic sel_bypass;
  logic sel_idcode;
  logic sel_extension;

  // ########################################
  // Controller and datapath
  // ########################################
  jtag_tap_fsm u_fsm (
    .JTAG_CLOCK       (JTAG_CLOCK),
    .reset_N          (reset_N),
    .tms              (tms),
    .capture_dr       (capture_dr),
    .shift_dr         (shift_dr),
    .update_dr        (update_dr),
    .capture_ir       (capture_ir),
    .shift_ir         (shift_ir),
    .update_ir        (update_ir),
    .run_idle         (run_idle),
    .test_logic_reset (test_logic_reset)
  );

  jtag_ir u_ir (
    .JTAG_CLOCK       (JTAG_CLOCK),
    .reset_N          (reset_N),
    .tdi              (tdi),
    .user_status      (user_status),
    .capture_ir       (capture_ir),
    .shift_ir         (shift_ir),
    .update_ir        (update_ir),
    .test_logic_reset (test_logic_reset),
    .ir               (ir),
    .ir_tdo           (ir_tdo),
    .sel_boundary     (sel_boundary),
    .sel_bypass       (sel_bypass),
    .sel_idcode       (sel_idcode),
    .sel_extension    (sel_extension)
  );

  jtag_id_bypass #(
    .ID_CODE (ID_CODE)
  ) u_dr (
    .JTAG_CLOCK    (JTAG_CLOCK),
    .reset_N       (reset_N),
    .tdi           (tdi),
    .capture_dr    (capture_dr),
    .shift_dr      (shift_dr),
    .sel_idcode    (sel_idcode),
    .sel_bypass    (sel_bypass),
    .sel_boundary  (sel_boundary),
    .sel_extension (sel_extension),
    .dr_tdo        (dr_tdo),
    .scan_in       (scan_in),
    .escan_in      (escan_in)
  );

  jtag_tdo_mux u_tdo (
    .JTAG_CLOCK    (JTAG_CLOCK),
    .reset_N       (reset_N),
    .tdi           (tdi),
    .shift_ir      (shift_ir),
    .shift_dr      (shift_dr),
    .sel_boundary  (sel_boundary),
    .sel_extension (sel_extension),
    .ir_tdo        (ir_tdo),
    .dr_tdo        (dr_tdo),
    .scan_out      (scan_out),
    .escan_out     (escan_out),
    .probe_enable  (probe_enable),
    .probe_tdo     (probe_tdo),
    .tdo           (tdo),
    .debug_int     (debug_int)
  );

endmodule

/* verification/jtag_checker.sv */
`timescale 1ns/100ps

module jtag_checker
  import jtag_pkg::*;
#(
  parameter logic [ID_WIDTH-2:0] ID_CODE = '0
)
(
  input  logic                 JTAG_CLOCK,
  input  logic                 reset_N,
  input  logic                 tms,
  input  logic                 tdi,
  input  logic [USR_WIDTH-1:0] user_status,
  input  logic                 scan_out,
  input  logic                 escan_out,
  input  logic                 scan_in,
  input  logic                 escan_in,
  input  logic                 probe_enable,
  input  logic                 probe_tdo,
  input  logic                 tdo,
  input  logic                 debug_int,
  input  logic                 capture_dr,
  input  logic                 shift_dr,
  input  logic                 update_dr,
  input  logic                 shift_ir,
  input  logic                 run_idle,
  input  logic                 test_logic_reset,
  input  logic [IR_WIDTH-1:0]  ir,
  input  logic [8*12-1:0]      test_name,
  output int                   errors
);

  tap_state_e          st;
  logic [IR_WIDTH-1:0] exp_ir;
  logic [IR_WIDTH-1:0] ir_scan;
  logic [ID_WIDTH-1:0] id_scan;
  logic                byp;
  logic                tdo_q;
  logic                chain_bit;
  int                  chain; // 0 boundary, 1 bypass, 2 idcode, 3 extension

  // ########################################
  // Reference TAP graph and chain decode
  // ########################################
  function automatic tap_state_e next_state(input tap_state_e s, input logic t);
    case (s)
      ST_TEST_LOGIC_RESET: return t ? ST_TEST_LOGIC_RESET : ST_RUN_IDLE;
      ST_RUN_IDLE:         return t ? ST_SELECT_DR : ST_RUN_IDLE;
      ST_SELECT_DR:        return t ? ST_SELECT_IR : ST_CAPTURE_DR;
      ST_CAPTURE_DR:       return t ? ST_EXIT1_DR : ST_SHIFT_DR;
      ST_SHIFT_DR:         return t ? ST_EXIT1_DR : ST_SHIFT_DR;
      ST_EXIT1_DR:         return t ? ST_UPDATE_DR : ST_PAUSE_DR;
      ST_PAUSE_DR:         return t ? ST_EXIT2_DR : ST_PAUSE_DR;
      ST_EXIT2_DR:         return t ? ST_UPDATE_DR : ST_SHIFT_DR;
      ST_UPDATE_DR:        return t ? ST_SELECT_DR : ST_RUN_IDLE;
      ST_SELECT_IR:        return t ? ST_TEST_LOGIC_RESET : ST_CAPTURE_IR;
      ST_CAPTURE_IR:       return t ? ST_EXIT1_IR : ST_SHIFT_IR;
      ST_SHIFT_IR:         return t ? ST_EXIT1_IR : ST_SHIFT_IR;
      ST_EXIT1_IR:         return t ? ST_UPDATE_IR : ST_PAUSE_IR;
      ST_PAUSE_IR:         return t ? ST_EXIT2_IR : ST_PAUSE_IR;
      ST_EXIT2_IR:         return t ? ST_UPDATE_IR : ST_SHIFT_IR;
      default:             return t ? ST_SELECT_DR : ST_RUN_IDLE; // Update-IR
    endcase
  endfunction

  function automatic int chain_of(input logic [IR_WIDTH-1:0] code);
    case (code)
      INSN_EXTEST, INSN_SAMPLE, INSN_CUST0, INSN_CUST1, INSN_CUST2, INSN_CUST3:
        return 0;
      INSN_INTEST, INSN_HIZ, INSN_CLAMP, INSN_BYPASS1, INSN_BYPASS:
        return 1;
      INSN_IDCODE:
        return 2;
      default:
        return 3;
    endcase
  endfunction

  task automatic check(input string what,
                       input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected)
    begin
      errors = errors + 1;
      $display("ERROR %0s %0s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  initial
    errors = 0;

  // ########################################
  // Compare on the rising edge, then step
  // ########################################
  always @(posedge JTAG_CLOCK)
  begin
    if (!reset_N)
    begin
      st      = ST_TEST_LOGIC_RESET;
      exp_ir  = INSN_IDCODE;
      ir_scan = '0;
      id_scan = '0;
      byp     = 1'b0;
      tdo_q   = 1'b0;
    end
    else
    begin
      chain = chain_of(exp_ir);
      check("strobes",
            {st == ST_CAPTURE_DR, st == ST_SHIFT_DR, st == ST_UPDATE_DR,
             st == ST_SHIFT_IR, st == ST_RUN_IDLE, st == ST_TEST_LOGIC_RESET},
            {capture_dr, shift_dr, update_dr, shift_ir, run_idle, test_logic_reset});
      check("ir", exp_ir, ir);
      case (chain)
        0:       chain_bit = scan_out;
        1:       chain_bit = byp;
        2:       chain_bit = id_scan[0];
        default: chain_bit = escan_out;
      endcase
      if (st == ST_SHIFT_IR)
        tdo_q = ir_scan[0];
      else if (st == ST_SHIFT_DR)
        tdo_q = chain_bit; // Taken on the last falling edge
      check("tdo", probe_enable ? probe_tdo : tdo_q, tdo);
      check("debug_int", probe_enable ? !tdi : 1'b0, debug_int);
      check("scan_in", st == ST_SHIFT_DR && chain == 0 && tdi, scan_in);
      check("escan_in", st == ST_SHIFT_DR && chain == 3 && tdi, escan_in);

      if (st == ST_CAPTURE_DR && chain == 2)
        id_scan = {ID_CODE, 1'b1};
      else if (st == ST_SHIFT_DR && chain == 2)
        id_scan = {tdi, id_scan[ID_WIDTH-1:1]};
      if (st == ST_SHIFT_DR && chain == 1)
        byp = tdi;
      if (st == ST_TEST_LOGIC_RESET)
        exp_ir = INSN_IDCODE;
      else if (st == ST_UPDATE_IR)
        exp_ir = ir_scan;
      if (st == ST_CAPTURE_IR)
        ir_scan = {user_status, 2'b01};
      else if (st == ST_SHIFT_IR)
        ir_scan = {tdi, ir_scan[IR_WIDTH-1:1]};
      st = next_state(st, tms);
    end
  end

endmodule

/* verification/jtag_tb.sv */
`timescale 1ns/100ps

module jtag_tb
  import jtag_pkg::*;
();

  localparam logic [ID_WIDTH-2:0] ID_CODE = 31'h1B3D_5A4F;

  logic                 JTAG_CLOCK;
  logic                 reset_N;
  logic                 tms;
  logic                 tdi;
  logic [USR_WIDTH-1:0] user_status;
  logic                 scan_out;
  logic                 escan_out;
  logic                 scan_in;
  logic                 escan_in;
  logic                 probe_enable;
  logic                 probe_tdo;
  logic                 tdo;
  logic                 debug_int;
  logic                 capture_dr;
  logic                 shift_dr;
  logic                 update_dr;
  logic                 shift_ir;
  logic                 run_idle;
  logic                 test_logic_reset;
  logic [IR_WIDTH-1:0]  ir;
  logic [8*12-1:0]      test_name;
  int                   errors;
  int                   timeouts;
  logic [31:0]          seed;
  logic [7:0]           bchain;
  logic [7:0]           echain;
  logic [1:0]           chain_sel; // 1 boundary, 2 extension

  jtag_tap_top #(
    .ID_CODE (ID_CODE)
  ) dut (.*);

  jtag_checker #(
    .ID_CODE (ID_CODE)
  ) chk (.*);

  initial
  begin
    JTAG_CLOCK = 1'b0;
    forever #2 JTAG_CLOCK = ~JTAG_CLOCK;
  end

  // ########################################
  // External chains, eight cells each
  // ########################################
  always @(posedge JTAG_CLOCK)
  begin
    if (shift_dr && chain_sel == 2'd1)
      bchain <= {scan_in, bchain[7:1]};
    if (shift_dr && chain_sel == 2'd2)
      echain <= {escan_in, echain[7:1]};
  end

  assign scan_out  = bchain[0];
  assign escan_out = echain[0];

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic rand_bit();
    seed = lcg_next(seed);
    return seed[16];
  endfunction

  // Called on a falling edge, returns on the next one
  task automatic drive(input logic t, input logic d);
    tms       = t;
    tdi       = d;
    probe_tdo = rand_bit();
    @(negedge JTAG_CLOCK);
  endtask

  task automatic to_idle();
    repeat (5)
      drive(1'b1, 1'b0);
    drive(1'b0, 1'b0);
  endtask

  // One IR or DR scan from Run-Test/Idle and back
  task automatic scan(input bit is_ir, input int nbits, input logic [IR_WIDTH-1:0] code);
    int i;
    int n;
    seed        = lcg_next(seed);
    user_status = seed[18:16];
    drive(1'b1, 1'b0);
    if (is_ir)
      drive(1'b1, 1'b0);
    drive(1'b0, 1'b0);
    n = 0;
    while (!(is_ir ? shift_ir : shift_dr) && n < 8)
    begin
      drive(1'b0, 1'b0);
      n++;
    end
    if (!(is_ir ? shift_ir : shift_dr))
    begin
      timeouts++;
      $display("Timeout: the TAP never reached its %0s shift state", is_ir ? "IR" : "DR");
    end
    for (i = 0; i < nbits; i++)
      drive(i == nbits - 1, is_ir ? code[i] : rand_bit());
    drive(1'b1, 1'b0); // Exit1 to Update
    drive(1'b0, 1'b0);
  endtask

  // ########################################
  // Test sequence
  // ########################################
  initial
  begin
    seed         = 32'h219;
    reset_N      = 1'b0;
    tms          = 1'b1;
    tdi          = 1'b0;
    user_status  = '0;
    probe_enable = 1'b0;
    probe_tdo    = 1'b0;
    bchain       = 8'h96;
    echain       = 8'h3C;
    chain_sel    = 2'd0;
    timeouts     = 0;
    test_name    = "reset";
    repeat (3)
      @(posedge JTAG_CLOCK);
    @(negedge JTAG_CLOCK);
    reset_N = 1'b1;

    to_idle();
    test_name = "idcode";
    scan(1'b0, 64, '0); // ID word, then the bits shifted in
    test_name = "tms_walk";
    repeat (80)
      drive(rand_bit(), rand_bit());
    to_idle();
    test_name = "ir_scan";
    scan(1'b1, IR_WIDTH, INSN_BYPASS);
    test_name = "bypass";
    scan(1'b0, 24, '0);
    test_name = "sample";
    chain_sel = 2'd1;
    scan(1'b1, IR_WIDTH, INSN_SAMPLE);
    scan(1'b0, 24, '0);
    test_name = "extension";
    chain_sel = 2'd2;
    scan(1'b1, IR_WIDTH, 5'b1_0000); // Unassigned code
    scan(1'b0, 24, '0);
    test_name    = "probe";
    chain_sel    = 2'd0;
    probe_enable = 1'b1;
    scan(1'b0, 16, '0);
    probe_enable = 1'b0;
    to_idle();

    $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* vlog.f */
verilog/jtag_pkg.sv
verilog/jtag_tap_fsm.sv
verilog/jtag_ir.sv
verilog/jtag_id_bypass.sv
verilog/jtag_tdo_mux.sv
verilog/jtag_tap_top.sv
verification/jtag_checker.sv
verification/jtag_tb.sv
